// ==== verif/mdu_golden.txt ====
# Columns: funct3 operand_a operand_b expected_result, all in hex.
# funct3: 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU, 4 DIV, 5 DIVU, 6 REM, 7 REMU.
0 00000007 00000006 0000002a
1 00000007 00000006 00000000
3 00000007 00000006 00000000
2 00000007 00000006 00000000
4 00000014 00000006 00000003
6 00000014 00000006 00000002
0 ffffffff ffffffff 00000001
1 ffffffff ffffffff 00000000
3 ffffffff ffffffff fffffffe
2 ffffffff ffffffff ffffffff
4 ffffffec 00000006 fffffffd
6 ffffffec 00000006 fffffffe
0 fffffffd fffffffb 0000000f
1 fffffffd fffffffb 00000000
3 fffffffd fffffffb fffffff8
2 fffffffd fffffffb fffffffd
4 00000014 fffffffa fffffffd
6 00000014 fffffffa 00000002
4 ffffffec fffffffa 00000003
6 ffffffec fffffffa fffffffe
2 80000000 80000000 c0000000
1 80000000 80000000 40000000
3 80000000 80000000 40000000
0 80000000 80000000 00000000
5 ffffffec 00000006 2aaaaaa7
7 ffffffec 00000006 00000002
5 00000014 fffffffa 00000000
7 00000014 fffffffa 00000014
1 80000000 00000002 ffffffff
0 80000000 00000002 00000000
3 80000000 00000002 00000001
2 fffffffe 00000003 ffffffff
4 00001234 00000000 ffffffff
5 00001234 00000000 ffffffff
6 00001234 00000000 00001234
7 00001234 00000000 00001234
6 80000001 00000000 80000001
4 ffffffff 00000000 ffffffff
0 fffffffe 00000003 fffffffa
2 00000003 fffffffe 00000002
3 12345678 00010000 00001234
0 12345678 00010000 56780000
4 80000000 ffffffff 80000000
6 80000000 ffffffff 00000000
5 80000000 ffffffff 00000000
7 80000000 ffffffff 80000000
4 80000000 00000001 80000000
6 80000000 00000001 00000000
1 12345678 fffffff0 fffffffe
0 12345678 fffffff0 dcba9880
0 0000ffff 0000ffff fffe0001
1 7fffffff 7fffffff 3fffffff
4 80000000 00000002 c0000000
5 80000000 00000002 40000000
5 ffffffff 00000010 0fffffff
7 ffffffff 00000010 0000000f
4 fffffff9 00000002 fffffffd
6 fffffff9 00000002 ffffffff
5 12345678 00001000 00012345
7 12345678 00001000 00000678

// ==== list.f ====
hdl/mdu_pkg.sv
hdl/div_core.sv
hdl/divider.sv
hdl/multiplier.sv
hdl/mdu_top.sv
verif/tb_mdu.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks its output for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_mdu -f list.f -o tb_mdu || exit 1
out=$(./obj_dir/tb_mdu)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "No errors" && exit 0 || exit 1

// ==== verif/tb_mdu.sv ====
module tb_mdu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int XLEN       = 32;
	localparam int MUL_STAGES = 3;
	localparam int TAG_W      = mdu_pkg::TAG_W;
	localparam int DIV_LAT    = XLEN + 2;
	localparam int MAX_OPS    = 256;
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;	// SUB/SRA encoding, not M-extension.

	logic			clk;
	logic			rst_n;
	logic			start;
	logic [6:0]		funct7;
	mdu_pkg::funct3_t	funct3;
	logic [XLEN-1:0]	a;
	logic [XLEN-1:0]	b;
	logic [TAG_W-1:0]	tag;
	logic			mul_done;
	logic [XLEN-1:0]	mul_result;
	logic [TAG_W-1:0]	mul_tag;
	logic			div_done;
	logic [XLEN-1:0]	div_result;
	logic [TAG_W-1:0]	div_tag;
	logic			div_busy;

	logic [2:0]		gold_f3 [MAX_OPS];
	logic [XLEN-1:0]	gold_a [MAX_OPS];
	logic [XLEN-1:0]	gold_b [MAX_OPS];
	logic [XLEN-1:0]	gold_res [MAX_OPS];
	int			n_ops = 0;
	int			cycle = 0;
	int			limit = 0;
	bit			loaded = 1'b0;
	int			passed = 0;
	int			failed = 0;
	int			stray = 0;
	int			busy_err = 0;
	int			mul_q [$];
	int			mul_cyc_q [$];
	int			div_q [$];
	int			div_cyc_q [$];

	mdu_top #(
		.XLEN		(XLEN),
		.MUL_STAGES	(MUL_STAGES)
	) i_mdu_top (
		.clk		(clk),
		.rst_n		(rst_n),
		.start		(start),
		.funct7		(funct7),
		.funct3		(funct3),
		.a		(a),
		.b		(b),
		.tag		(tag),
		.mul_done	(mul_done),
		.mul_result	(mul_result),
		.mul_tag	(mul_tag),
		.div_done	(div_done),
		.div_result	(div_result),
		.div_tag	(div_tag),
		.div_busy	(div_busy)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin : cycle_count
		cycle <= cycle + 1;
	end

	function automatic logic [TAG_W-1:0] tag_of(int idx);
		return TAG_W'(idx % 32);
	endfunction

	task automatic load_golden();
		int fd;
		int code;
		string line;
		logic [31:0] f;
		logic [31:0] x;
		logic [31:0] y;
		logic [31:0] r;
		fd = $fopen("verif/mdu_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open verif/mdu_golden.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line[0] != "#") begin
					code = $sscanf(line, "%h %h %h %h", f, x, y, r);
					if (code == 4 && n_ops < MAX_OPS) begin
						gold_f3[n_ops]  = f[2:0];
						gold_a[n_ops]   = x;
						gold_b[n_ops]   = y;
						gold_res[n_ops] = r;
						n_ops++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic count_test(string name, bit ok);
		if (ok) begin
			passed++;
			$display("%s passed", name);
		end else begin
			failed++;
			$display("%s failed", name);
		end
	endtask

	task automatic check_done(string unit_name, logic [XLEN-1:0] res, logic [TAG_W-1:0] res_tag,
			int idx, int issued, int exp_lat);
		bit ok;
		int lat;
		ok  = 1'b1;
		lat = cycle - issued - 1;	// The monitor sees done one edge after it rises.
		assert (res == gold_res[idx]) else begin
			$display("FAIL %s_result test %0d expected %h actual %h",
				unit_name, idx, gold_res[idx], res);
			ok = 1'b0;
		end
		assert (res_tag == tag_of(idx)) else begin
			$display("FAIL %s_tag test %0d expected %h actual %h",
				unit_name, idx, tag_of(idx), res_tag);
			ok = 1'b0;
		end
		assert (lat == exp_lat) else begin
			$display("Test %0d came out %0d cycles after issue instead of %0d",
				idx, lat, exp_lat);
			ok = 1'b0;
		end
		count_test($sformatf("test %0d funct3 %0d tag %h", idx, gold_f3[idx], tag_of(idx)), ok);
	endtask

	always @(posedge clk) begin : result_monitor
		int idx;
		int issued;
		bit busy_exp;
		if (rst_n) begin
			// Busy rises on the edge after acceptance and falls on the edge that raises done.
			busy_exp = div_cyc_q.size() != 0 && cycle - div_cyc_q[0] >= 2
				&& cycle - div_cyc_q[0] <= DIV_LAT;
			assert (div_busy == busy_exp) else begin
				busy_err++;
				$display("FAIL div_busy cycle %0d expected %h actual %h",
					cycle, busy_exp, div_busy);
			end
		end
		if (rst_n && mul_done) begin
			assert (mul_q.size() != 0) else begin
				stray++;
				$display("Multiplier done pulse at cycle %0d with nothing outstanding", cycle);
			end
			if (mul_q.size() != 0) begin
				idx    = mul_q.pop_front();
				issued = mul_cyc_q.pop_front();
				check_done("mul", mul_result, mul_tag, idx, issued, MUL_STAGES);
			end
		end
		if (rst_n && div_done) begin
			assert (div_q.size() != 0) else begin
				stray++;
				$display("Divider done pulse at cycle %0d with nothing outstanding", cycle);
			end
			if (div_q.size() != 0) begin
				idx    = div_q.pop_front();
				issued = div_cyc_q.pop_front();
				check_done("div", div_result, div_tag, idx, issued, DIV_LAT);
			end
		end
	end

	task automatic drive_op(logic [6:0] f7, logic [2:0] f3, logic [XLEN-1:0] op_a,
			logic [XLEN-1:0] op_b, logic [TAG_W-1:0] op_tag);
		@(posedge clk);
		start  <= 1'b1;
		funct7 <= f7;
		funct3 <= mdu_pkg::funct3_t'(f3);
		a      <= op_a;
		b      <= op_b;
		tag    <= op_tag;
	endtask

	task automatic idle_cycles(int n);
		repeat (n) begin
			@(posedge clk);
			start <= 1'b0;
		end
	endtask

	// Waits until the divider is idle and its last result has been checked.
	task automatic wait_div_idle();
		@(negedge clk);
		while (div_busy || div_q.size() != 0) begin
			@(posedge clk);
			start <= 1'b0;
			@(negedge clk);
		end
	endtask

	task automatic drain();
		@(negedge clk);
		while (mul_q.size() != 0 || div_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	task automatic issue_golden(int idx);
		if (gold_f3[idx][2]) begin
			wait_div_idle();
		end
		drive_op(mdu_pkg::FUNCT7_M, gold_f3[idx], gold_a[idx], gold_b[idx], tag_of(idx));
		if (gold_f3[idx][2]) begin
			div_q.push_back(idx);
			div_cyc_q.push_back(cycle);
		end else begin
			mul_q.push_back(idx);
			mul_cyc_q.push_back(cycle);
		end
	endtask

	task automatic ignored_op(string name, int idx, int settle);
		int stray0;
		bit ok;
		ok = 1'b1;
		if (gold_f3[idx][2]) begin
			wait_div_idle();
		end
		stray0 = stray;
		drive_op(FUNCT7_ALT, gold_f3[idx], gold_a[idx], gold_b[idx], tag_of(idx));
		idle_cycles(settle);
		assert (stray == stray0) else begin
			$display("An operation without the M-extension funct7 gave a done pulse");
			ok = 1'b0;
		end
		count_test(name, ok);
	endtask

	task automatic busy_drop(int idx);
		int stray0;
		bit ok;
		ok = 1'b1;
		wait_div_idle();
		stray0 = stray;
		issue_golden(idx);
		idle_cycles(1);
		drive_op(mdu_pkg::FUNCT7_M, 3'b101, ~gold_a[idx], 32'h1, tag_of(idx + 1));	// Busy here.
		idle_cycles(1);
		drain();
		idle_cycles(DIV_LAT + 4);
		assert (stray == stray0) else begin
			$display("A divide issued while the divider was busy was not dropped");
			ok = 1'b0;
		end
		count_test("dropped divide while busy", ok);
	endtask

	initial begin : watchdog
		wait (loaded);
		while (cycle < limit) begin
			@(posedge clk);
		end
		$display("Timeout after %0d cycles with results still outstanding", limit);
		$display("Errors found");
		$finish;
	end

	initial begin : stimulus
		int first_mul;
		int first_div;
		rst_n  <= 1'b0;
		start  <= 1'b0;
		funct7 <= '0;
		funct3 <= mdu_pkg::MUL;
		a      <= '0;
		b      <= '0;
		tag    <= '0;
		first_mul = -1;
		first_div = -1;
		void'($urandom(32'h3f03_35e0));
		load_golden();
		limit  = n_ops * (XLEN + 5) + 100;
		loaded = 1'b1;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int i = 0; i < n_ops; i++) begin
			issue_golden(i);
			// A multiply that follows a multiply goes in back to back.
			if (gold_f3[i][2] || i + 1 >= n_ops || gold_f3[i + 1][2]) begin
				idle_cycles(int'($urandom % 3));
			end
			if (gold_f3[i][2] && first_div < 0) first_div = i;
			if (!gold_f3[i][2] && first_mul < 0) first_mul = i;
		end
		idle_cycles(1);
		drain();
		if (first_mul >= 0) ignored_op("non-M multiply ignored", first_mul, MUL_STAGES + 4);
		if (first_div >= 0) ignored_op("non-M divide ignored", first_div, DIV_LAT + 4);
		if (first_div >= 0) busy_drop(first_div);
		$display("passed %0d, failed %0d, stray done pulses %0d, busy errors %0d",
			passed, failed, stray, busy_err);
		if (n_ops > 0 && failed == 0 && stray == 0 && busy_err == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule : tb_mdu

// ==== hdl/mdu_top.sv ====
module mdu_top #(
	parameter int XLEN       = 32,
	parameter int MUL_STAGES = 3
) (
	input	logic				clk,
	input	logic				rst_n,
	input	logic				start,
	input	logic [6:0]			funct7,
	input	mdu_pkg::funct3_t		funct3,
	input	logic [XLEN-1:0]		a,
	input	logic [XLEN-1:0]		b,
	input	logic [mdu_pkg::TAG_W-1:0]	tag,

	output	logic				mul_done,
	output	logic [XLEN-1:0]		mul_result,
	output	logic [mdu_pkg::TAG_W-1:0]	mul_tag,
	output	logic				div_done,
	output	logic [XLEN-1:0]		div_result,
	output	logic [mdu_pkg::TAG_W-1:0]	div_tag,
	output	logic				div_busy
);

	logic	m_op;
	logic	mul_start;
	logic	div_start;

	// Only M-extension encodings reach either unit.
	assign m_op      = start && (funct7 == mdu_pkg::FUNCT7_M);
	assign mul_start = m_op && !funct3[2];
	assign div_start = m_op && funct3[2];	// The divider itself drops it when busy.

	multiplier #(
		.XLEN		(XLEN),
		.MUL_STAGES	(MUL_STAGES)
	) i_multiplier (
		.clk		(clk),
		.rst_n		(rst_n),
		.start		(mul_start),
		.funct3		(funct3),
		.a		(a),
		.b		(b),
		.tag		(tag),
		.done		(mul_done),
		.result		(mul_result),
		.tag_out	(mul_tag)
	);

	divider #(
		.XLEN		(XLEN)
	) i_divider (
		.clk		(clk),
		.rst_n		(rst_n),
		.start		(div_start),
		.funct3		(funct3),
		.a		(a),
		.b		(b),
		.tag		(tag),
		.done		(div_done),
		.result		(div_result),
		.tag_out	(div_tag),
		.busy		(div_busy)
	);

endmodule : mdu_top

// ==== hdl/multiplier.sv ====
module multiplier #(
	parameter int XLEN       = 32,
	parameter int MUL_STAGES = 3
) (
	input	logic				clk,
	input	logic				rst_n,
	input	logic				start,
	input	mdu_pkg::funct3_t		funct3,
	input	logic [XLEN-1:0]		a,
	input	logic [XLEN-1:0]		b,
	input	logic [mdu_pkg::TAG_W-1:0]	tag,

	output	logic				done,
	output	logic [XLEN-1:0]		result,
	output	logic [mdu_pkg::TAG_W-1:0]	tag_out
);

	localparam int LAST = MUL_STAGES - 1;

	logic				a_signed;
	logic				b_signed;
	logic				hi_sel;
	logic signed [XLEN:0]		a_ext;
	logic signed [XLEN:0]		b_ext;
	logic signed [2*XLEN+1:0]	product;

	logic [MUL_STAGES-1:0]		valid_q;
	logic [MUL_STAGES-1:0]		hi_q;
	logic [2*XLEN-1:0]		prod_q [MUL_STAGES];
	logic [mdu_pkg::TAG_W-1:0]	tag_q [MUL_STAGES];

	always_comb begin : operand_ext
		case (funct3)
			mdu_pkg::MULH: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
				hi_sel   = 1'b1;
			end
			mdu_pkg::MULHSU: begin
				a_signed = 1'b1;
				b_signed = 1'b0;
				hi_sel   = 1'b1;
			end
			mdu_pkg::MULHU: begin
				a_signed = 1'b0;
				b_signed = 1'b0;
				hi_sel   = 1'b1;
			end
			default: begin	// MUL, where only the low word is kept.
				a_signed = 1'b1;
				b_signed = 1'b1;
				hi_sel   = 1'b0;
			end
		endcase
		a_ext   = {a_signed && a[XLEN-1], a};
		b_ext   = {b_signed && b[XLEN-1], b};
		product = a_ext * b_ext;	// 2*XLEN+2 bits, the top two are only sign.
	end

	always_ff @(posedge clk or negedge rst_n) begin : valid_pipe
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= start;
			for (int i = 1; i < MUL_STAGES; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin : data_pipe
		prod_q[0] <= product[2*XLEN-1:0];
		hi_q[0]   <= hi_sel;
		tag_q[0]  <= tag;
		for (int i = 1; i < MUL_STAGES; i++) begin
			prod_q[i] <= prod_q[i-1];
			hi_q[i]   <= hi_q[i-1];
			tag_q[i]  <= tag_q[i-1];
		end
	end

	assign done    = valid_q[LAST];
	assign result  = hi_q[LAST] ? prod_q[LAST][2*XLEN-1:XLEN] : prod_q[LAST][XLEN-1:0];
	assign tag_out = tag_q[LAST];

endmodule : multiplier

// ==== hdl/divider.sv ====
module divider #(
	parameter int XLEN = 32
) (
	input	logic				clk,
	input	logic				rst_n,
	input	logic				start,
	input	mdu_pkg::funct3_t		funct3,
	input	logic [XLEN-1:0]		a,
	input	logic [XLEN-1:0]		b,
	input	logic [mdu_pkg::TAG_W-1:0]	tag,

	output	logic				done,
	output	logic [XLEN-1:0]		result,
	output	logic [mdu_pkg::TAG_W-1:0]	tag_out,
	output	logic				busy
);

	localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

	logic			accept;
	logic			is_signed;
	logic			is_rem;
	logic			a_neg;
	logic			b_neg;
	logic [XLEN-1:0]	a_mag;
	logic [XLEN-1:0]	b_mag;
	logic [XLEN-1:0]	special;
	logic [XLEN-1:0]	special_q;
	logic			q_neg_q;
	logic			r_neg_q;
	logic			core_start;
	logic [XLEN-1:0]	dividend_q;
	logic [XLEN-1:0]	divisor_q;
	logic			core_done;
	logic [XLEN-1:0]	core_quo;
	logic [XLEN-1:0]	core_rem;
	logic [XLEN-1:0]	final_result;

	mdu_pkg::div_case_t	div_case;
	mdu_pkg::div_case_t	div_case_q;

	assign accept = start && !busy;	// A strobe during a running divide is dropped.

	always_comb begin : op_decode
		case (funct3)
			mdu_pkg::DIV: begin
				is_signed = 1'b1;
				is_rem    = 1'b0;
			end
			mdu_pkg::REM: begin
				is_signed = 1'b1;
				is_rem    = 1'b1;
			end
			mdu_pkg::REMU: begin
				is_signed = 1'b0;
				is_rem    = 1'b1;
			end
			default: begin
				is_signed = 1'b0;
				is_rem    = 1'b0;
			end
		endcase
	end

	always_comb begin : magnitudes
		a_neg = is_signed && a[XLEN-1];
		b_neg = is_signed && b[XLEN-1];
		a_mag = a_neg ? -a : a;	// MOST_NEG maps onto itself, which is right unsigned.
		b_mag = b_neg ? -b : b;
	end

	// Special results follow the RISC-V spec for zero divisors and signed overflow.
	always_comb begin : case_select
		if (b == '0) begin
			div_case = mdu_pkg::div_by_0_div;
			special  = is_rem ? a : {XLEN{1'b1}};
		end else if (is_signed && a == MOST_NEG && b == {XLEN{1'b1}}) begin
			div_case = mdu_pkg::overflow_div;
			special  = is_rem ? '0 : MOST_NEG;
		end else begin
			div_case = is_rem ? mdu_pkg::normal_rem : mdu_pkg::normal_div;
			special  = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin : sequencer
		if (!rst_n) begin
			busy       <= 1'b0;
			core_start <= 1'b0;
			done       <= 1'b0;
		end else begin
			core_start <= accept;
			done       <= core_done;
			if (accept) begin
				busy <= 1'b1;
			end else if (core_done) begin
				busy <= 1'b0;	// Low together with done so the next divide can issue.
			end
		end
	end

	always_ff @(posedge clk) begin : op_latch
		if (accept) begin
			dividend_q <= a_mag;
			divisor_q  <= b_mag;
			div_case_q <= div_case;
			special_q  <= special;
			q_neg_q    <= a_neg ^ b_neg;
			r_neg_q    <= a_neg;	// Remainder takes the sign of the dividend.
			tag_out    <= tag;
		end
		if (core_done) begin
			result <= final_result;
		end
	end

	div_core #(
		.XLEN		(XLEN)
	) i_div_core (
		.clk		(clk),
		.rst_n		(rst_n),
		.start		(core_start),
		.dividend	(dividend_q),
		.divisor	(divisor_q),
		.done		(core_done),
		.quotient	(core_quo),
		.remainder	(core_rem)
	);

	always_comb begin : result_select
		unique case (div_case_q)
			mdu_pkg::normal_div:	final_result = q_neg_q ? -core_quo : core_quo;
			mdu_pkg::normal_rem:	final_result = r_neg_q ? -core_rem : core_rem;
			default:		final_result = special_q;
		endcase
	end

endmodule : divider

// ==== hdl/div_core.sv ====
module div_core #(
	parameter int XLEN = 32
) (
	input	logic			clk,
	input	logic			rst_n,
	input	logic			start,
	input	logic [XLEN-1:0]	dividend,
	input	logic [XLEN-1:0]	divisor,

	output	logic			done,
	output	logic [XLEN-1:0]	quotient,
	output	logic [XLEN-1:0]	remainder
);

	localparam int CNT_W = $clog2(XLEN + 1);

	logic [CNT_W-1:0]	bits_left;
	logic [XLEN-1:0]	divisor_q;
	logic [XLEN-1:0]	rem_in;
	logic [XLEN-1:0]	quo_in;
	logic [XLEN-1:0]	div_in;
	logic [XLEN:0]		partial;
	logic [XLEN+1:0]	trial;
	logic			fits;
	logic			step;

	// The first quotient bit is produced on the start edge itself,
	// so XLEN bits take exactly XLEN cycles.
	assign step = start || (bits_left != '0);

	always_comb begin : step_operands
		rem_in = start ? '0 : remainder;
		quo_in = start ? dividend : quotient;
		div_in = start ? divisor : divisor_q;
	end

	always_comb begin : trial_subtract
		partial = {rem_in, quo_in[XLEN-1]};	// Shift in the next dividend bit.
		trial   = {1'b0, partial} - {2'b00, div_in};
		fits    = !trial[XLEN+1];		// No borrow means the divisor fits.
	end

	always_ff @(posedge clk or negedge rst_n) begin : bit_counter
		if (!rst_n) begin
			bits_left <= '0;
			done      <= 1'b0;
		end else if (start) begin
			bits_left <= CNT_W'(XLEN - 1);
			done      <= 1'b0;
		end else if (bits_left != '0) begin
			bits_left <= bits_left - 1'b1;
			done      <= (bits_left == CNT_W'(1));	// Last bit goes in this cycle.
		end else begin
			done <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin : shift_subtract
		if (start) begin
			divisor_q <= divisor;
		end
		if (step) begin
			if (fits) begin
				remainder <= trial[XLEN-1:0];
			end else begin
				remainder <= partial[XLEN-1:0];	// Restore.
			end
			quotient <= {quo_in[XLEN-2:0], fits};
		end
	end

endmodule : div_core

// ==== hdl/mdu_pkg.sv ====
package mdu_pkg;

	// Width of the destination-register tag that rides along with each operation.
	localparam int TAG_W = 5;

	localparam logic [6:0] FUNCT7_M = 7'b0000001;	// funct7 of every M-extension instruction.

	// Bit 2 splits the space: clear goes to the multiplier, set goes to the divider.
	typedef enum logic [2:0] {
		MUL    = 3'b000,	// Low word, sign does not matter.
		MULH   = 3'b001,	// High word of signed x signed.
		MULHSU = 3'b010,	// High word of signed a x unsigned b.
		MULHU  = 3'b011,	// High word of unsigned x unsigned.
		DIV    = 3'b100,
		DIVU   = 3'b101,
		REM    = 3'b110,
		REMU   = 3'b111
	} funct3_t;

	// How the divider forms its final result once the core has finished.
	typedef enum logic [1:0] {
		normal_div   = 2'b00,	// Sign-corrected quotient.
		normal_rem   = 2'b01,	// Sign-corrected remainder.
		overflow_div = 2'b10,	// Most negative value divided by minus one.
		div_by_0_div = 2'b11	// Zero divisor.
	} div_case_t;

endpackage : mdu_pkg
